// ==== verilog/fcore_pkg.sv ====
package fcore_pkg;

    // Host bus address and data word
    localparam int bus_width = 32;

    // Register file word and acquisition sample
    localparam int datapath_width = 20;

    // Register file addressing
    localparam int reg_addr_width = 6;
    localparam int reg_count = 64;

    // Control word sits at the base, data register k at base + 4 + 4*k
    localparam logic [bus_width-1:0] base_address = 32'h43c00000;

    // Recovery cycles after each host read
    localparam int pulse_stretch_length = 6;

    // Active channel count held in the control word
    localparam int channel_width = 8;

endpackage

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 write_valid,
    input  logic [fcore_pkg::reg_addr_width-1:0] write_addr,
    input  logic [fcore_pkg::datapath_width-1:0] write_data,
    input  logic [fcore_pkg::reg_addr_width-1:0] read_addr,
    output logic [fcore_pkg::datapath_width-1:0] read_data
);
    import fcore_pkg::*;

    logic [datapath_width-1:0] mem [reg_count];

    // Write port with every word cleared on reset
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < reg_count; i++) begin
                mem[i] <= '0;
            end
        end else if (write_valid) begin
            mem[write_addr] <= write_data;
        end
    end

    // Synchronous read returning old data on a same-cycle write to the same word
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            read_data <= '0;
        end else begin
            read_data <= mem[read_addr];
        end
    end

endmodule

// ==== verilog/sample_streamer.sv ====
`timescale 1ns/1ps

module sample_streamer (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 sample_valid,
    input  logic [fcore_pkg::datapath_width-1:0] sample_data,
    input  logic [fcore_pkg::channel_width-1:0]  n_channels,
    output logic                                 stream_valid,
    output logic [fcore_pkg::reg_addr_width-1:0] stream_dest,
    output logic [fcore_pkg::datapath_width-1:0] stream_data
);
    import fcore_pkg::*;

    logic [channel_width-1:0]  n_channels_q;
    logic [channel_width-1:0]  effective_count;
    logic                      channel_changed;
    logic [reg_addr_width-1:0] channel_index;
    logic [reg_addr_width-1:0] base_index;
    logic [channel_width-1:0]  index_plus_one;
    logic [reg_addr_width-1:0] next_index;

    // Counts beyond the register file behave as a full rotation
    assign effective_count = (n_channels > channel_width'(reg_count))
                           ? channel_width'(reg_count) : n_channels;

    // A new channel count restarts the rotation at 0
    assign channel_changed = n_channels != n_channels_q;
    assign base_index = channel_changed ? '0 : channel_index;

    assign index_plus_one = channel_width'(base_index) + 1'b1;
    assign next_index = (index_plus_one >= effective_count)
                      ? '0 : index_plus_one[reg_addr_width-1:0];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            n_channels_q <= '0;
            channel_index <= '0;
            stream_valid <= 1'b0;
        end else begin
            n_channels_q <= n_channels;
            // No channels means the sample is dropped
            stream_valid <= sample_valid && (effective_count != '0);
            if (sample_valid && (effective_count != '0)) begin
                channel_index <= next_index;
            end else begin
                channel_index <= base_index;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sample_valid) begin
            stream_dest <= base_index;
            stream_data <= sample_data;
        end
    end

    // Destination bounded by the count it was tagged under, hence below reg_count
    dest_in_range: assert property (
        @(posedge clock) disable iff (!reset)
        stream_valid |-> (channel_width'(stream_dest) < $past(effective_count))
    ) else $error("stream_dest outside the active channels");

endmodule

// ==== verilog/dma_endpoint.sv ====
`timescale 1ns/1ps

module dma_endpoint (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [fcore_pkg::bus_width-1:0]      sb_address,
    input  logic [fcore_pkg::bus_width-1:0]      sb_write_data,
    input  logic                                 sb_write_strobe,
    input  logic                                 sb_read_strobe,
    output logic                                 sb_ready,
    output logic [fcore_pkg::bus_width-1:0]      sb_read_data,
    output logic                                 sb_read_valid,
    input  logic                                 stream_valid,
    input  logic [fcore_pkg::reg_addr_width-1:0] stream_dest,
    input  logic [fcore_pkg::datapath_width-1:0] stream_data,
    output logic                                 reg_write_valid,
    output logic [fcore_pkg::reg_addr_width-1:0] reg_write_addr,
    output logic [fcore_pkg::datapath_width-1:0] reg_write_data,
    output logic [fcore_pkg::reg_addr_width-1:0] reg_read_addr,
    input  logic [fcore_pkg::datapath_width-1:0] reg_read_data,
    output logic [fcore_pkg::channel_width-1:0]  n_channels
);
    import fcore_pkg::*;

    enum logic [2:0] {
        st_idle,
        st_host_write,
        st_read_addr,
        st_read_capture,
        st_pulse_stretch
    } state;

    logic [bus_width-1:0]                    strobe_offset;
    logic [bus_width-1:0]                    strobe_index_offset;
    logic [bus_width-1:0]                    latched_offset;
    logic [bus_width-1:0]                    latched_index_offset;
    logic [datapath_width-1:0]               latched_data;
    logic                                    latched_is_control;
    logic [reg_addr_width-1:0]               latched_index;
    logic [$clog2(pulse_stretch_length)-1:0] stretch_count;
    logic                                    accept_write;
    logic                                    accept_read;
    logic                                    host_write_go;

    // Offset from the control word, and from data register 0
    assign strobe_offset = sb_address - base_address;
    assign strobe_index_offset = strobe_offset - bus_width'(4);
    assign latched_index_offset = latched_offset - bus_width'(4);

    // Anything below the first data register is the control word
    assign latched_is_control = latched_offset < bus_width'(4);
    assign latched_index = latched_index_offset[reg_addr_width+1:2];

    assign accept_write = (state == st_idle) && sb_ready && sb_write_strobe;
    assign accept_read = (state == st_idle) && sb_ready && sb_read_strobe;

    // Stream writes own the port, the host write waits for a free cycle
    assign host_write_go = (state == st_host_write) && !stream_valid;

    // Address and data captured on either strobe
    always_ff @(posedge clock) begin
        if (accept_write || accept_read) begin
            latched_offset <= strobe_offset;
            latched_data <= sb_write_data[datapath_width-1:0];
        end
        // Read address goes out straight from the strobe to save a cycle
        if (accept_read) begin
            reg_read_addr <= strobe_index_offset[reg_addr_width+1:2];
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= st_idle;
            sb_ready <= 1'b1;
            sb_read_valid <= 1'b0;
            sb_read_data <= '0;
            n_channels <= '0;
            stretch_count <= '0;
        end else begin
            sb_read_valid <= 1'b0;
            sb_read_data <= '0;
            case (state)
                st_idle: begin
                    if (accept_write) begin
                        sb_ready <= 1'b0;
                        state <= st_host_write;
                    end else if (accept_read) begin
                        sb_ready <= 1'b0;
                        state <= st_read_addr;
                    end else begin
                        sb_ready <= 1'b1;
                    end
                end

                st_host_write: begin
                    // Ready comes back from idle, one cycle after the write
                    if (host_write_go) begin
                        if (latched_is_control) begin
                            n_channels <= latched_data[channel_width-1:0];
                        end
                        state <= st_idle;
                    end
                end

                st_read_addr: begin
                    // Register file is sampling the read address
                    state <= st_read_capture;
                end

                st_read_capture: begin
                    sb_read_valid <= 1'b1;
                    if (latched_is_control) begin
                        sb_read_data <= bus_width'(n_channels);
                    end else begin
                        sb_read_data <= bus_width'(reg_read_data);
                    end
                    stretch_count <= '0;
                    state <= st_pulse_stretch;
                end

                st_pulse_stretch: begin
                    if (int'(stretch_count) == pulse_stretch_length - 1) begin
                        sb_ready <= 1'b1;
                        state <= st_idle;
                    end else begin
                        stretch_count <= stretch_count + 1'b1;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Register write port
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            reg_write_valid <= 1'b0;
        end else begin
            reg_write_valid <= stream_valid || (host_write_go && !latched_is_control);
        end
    end

    always_ff @(posedge clock) begin
        if (stream_valid) begin
            reg_write_addr <= stream_dest;
            reg_write_data <= stream_data;
        end else if (host_write_go) begin
            reg_write_addr <= latched_index;
            reg_write_data <= latched_data;
        end
    end

    // Host must wait for ready before striking
    strobe_needs_ready: assert property (
        @(posedge clock) disable iff (!reset)
        (sb_write_strobe || sb_read_strobe) |-> sb_ready
    ) else $error("host strobe while sb_ready is low");

    single_strobe: assert property (
        @(posedge clock) disable iff (!reset)
        !(sb_write_strobe && sb_read_strobe)
    ) else $error("write and read strobe together");

    read_valid_pulse: assert property (
        @(posedge clock) disable iff (!reset)
        sb_read_valid |=> !sb_read_valid
    ) else $error("sb_read_valid high for two cycles");

endmodule

// ==== verilog/fcore_dma_top.sv ====
`timescale 1ns/1ps

module fcore_dma_top (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [fcore_pkg::bus_width-1:0]      sb_address,
    input  logic [fcore_pkg::bus_width-1:0]      sb_write_data,
    input  logic                                 sb_write_strobe,
    input  logic                                 sb_read_strobe,
    output logic                                 sb_ready,
    output logic [fcore_pkg::bus_width-1:0]      sb_read_data,
    output logic                                 sb_read_valid,
    input  logic                                 sample_valid,
    input  logic [fcore_pkg::datapath_width-1:0] sample_data
);
    import fcore_pkg::*;

    logic [channel_width-1:0]  n_channels;
    logic                      stream_valid;
    logic [reg_addr_width-1:0] stream_dest;
    logic [datapath_width-1:0] stream_data;
    logic                      reg_write_valid;
    logic [reg_addr_width-1:0] reg_write_addr;
    logic [datapath_width-1:0] reg_write_data;
    logic [reg_addr_width-1:0] reg_read_addr;
    logic [datapath_width-1:0] reg_read_data;

    sample_streamer u_sample_streamer (
        .clock        (clock),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .n_channels   (n_channels),
        .stream_valid (stream_valid),
        .stream_dest  (stream_dest),
        .stream_data  (stream_data)
    );

    dma_endpoint u_dma_endpoint (
        .clock           (clock),
        .reset           (reset),
        .sb_address      (sb_address),
        .sb_write_data   (sb_write_data),
        .sb_write_strobe (sb_write_strobe),
        .sb_read_strobe  (sb_read_strobe),
        .sb_ready        (sb_ready),
        .sb_read_data    (sb_read_data),
        .sb_read_valid   (sb_read_valid),
        .stream_valid    (stream_valid),
        .stream_dest     (stream_dest),
        .stream_data     (stream_data),
        .reg_write_valid (reg_write_valid),
        .reg_write_addr  (reg_write_addr),
        .reg_write_data  (reg_write_data),
        .reg_read_addr   (reg_read_addr),
        .reg_read_data   (reg_read_data),
        .n_channels      (n_channels)
    );

    register_file u_register_file (
        .clock       (clock),
        .reset       (reset),
        .write_valid (reg_write_valid),
        .write_addr  (reg_write_addr),
        .write_data  (reg_write_data),
        .read_addr   (reg_read_addr),
        .read_data   (reg_read_data)
    );

endmodule

// ==== tests/tb_fcore_dma.sv ====
`timescale 1ns/1ps

module tb_fcore_dma;
    import fcore_pkg::*;

    logic                      clock;
    logic                      reset;
    logic [bus_width-1:0]      sb_address;
    logic [bus_width-1:0]      sb_write_data;
    logic                      sb_write_strobe;
    logic                      sb_read_strobe;
    logic                      sb_ready;
    logic [bus_width-1:0]      sb_read_data;
    logic                      sb_read_valid;
    logic                      sample_valid;
    logic [datapath_width-1:0] sample_data;

    // Operation list from the vector file
    string                vec_op[$];
    logic [bus_width-1:0] vec_addr[$];
    logic [bus_width-1:0] vec_data[$];
    string                vec_expect[$];
    int                   vector_count = 0;

    // Expected contents of the register file and the control word
    logic [datapath_width-1:0] mirror_regs [reg_count];
    logic [channel_width-1:0]  mirror_channels;
    int                        mirror_index;

    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    fcore_dma_top u_fcore_dma_top (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // 20 cycles per vector plus the reset time
    initial begin
        wait (vector_count != 0);
        repeat (vector_count * 20 + 8) @(posedge clock);
        $display("Watchdog expired: the vectors did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    task automatic report_mismatch(input string what, input logic [bus_width-1:0] got,
                                   input logic [bus_width-1:0] expected);
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        errors++;
        test_errors++;
    endtask

    task automatic report_result(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s with %0d errors", name, test_errors);
        end
    endtask

    function automatic logic [bus_width-1:0] mirror_read(input logic [bus_width-1:0] addr);
        logic [bus_width-1:0] offset;
        offset = addr - base_address;
        if (offset == 0) begin
            return bus_width'(mirror_channels);
        end
        return bus_width'(mirror_regs[int'((offset - 32'd4) >> 2)]);
    endfunction

    task automatic mirror_host_write(input logic [bus_width-1:0] addr,
                                     input logic [bus_width-1:0] data);
        logic [bus_width-1:0] offset;
        offset = addr - base_address;
        if (offset == 0) begin
            // A new channel count restarts the rotation
            if (data[channel_width-1:0] != mirror_channels) begin
                mirror_index = 0;
            end
            mirror_channels = data[channel_width-1:0];
        end else begin
            mirror_regs[int'((offset - 32'd4) >> 2)] = data[datapath_width-1:0];
        end
    endtask

    task automatic mirror_sample(input logic [datapath_width-1:0] data);
        int active;
        active = (int'(mirror_channels) > reg_count) ? reg_count : int'(mirror_channels);
        if (active != 0) begin
            mirror_regs[mirror_index] = data;
            mirror_index = (mirror_index + 1 >= active) ? 0 : mirror_index + 1;
        end
    endtask

    task automatic host_write(input logic [bus_width-1:0] addr,
                              input logic [bus_width-1:0] data, input bit with_sample);
        logic [datapath_width-1:0] sample;
        int low_cycles;
        int expected_low;
        while (!sb_ready) @(negedge clock);
        sb_address = addr;
        sb_write_data = data;
        sb_write_strobe = 1'b1;
        if (with_sample) begin
            sample = datapath_width'($urandom);
            sample_valid = 1'b1;
            sample_data = sample;
            mirror_sample(sample);
        end
        mirror_host_write(addr, data);
        @(negedge clock);
        sb_write_strobe = 1'b0;
        sample_valid = 1'b0;
        low_cycles = 0;
        while (!sb_ready && low_cycles < 32) begin
            low_cycles++;
            @(negedge clock);
        end
        // Stream write in the same cycle costs the host one extra cycle
        expected_low = with_sample ? 3 : 2;
        if (low_cycles != expected_low) begin
            report_mismatch("sb_ready low cycles after write", low_cycles, expected_low);
        end
    endtask

    task automatic host_read(input logic [bus_width-1:0] addr,
                             input logic [bus_width-1:0] expected);
        int latency;
        int stretch;
        while (!sb_ready) @(negedge clock);
        sb_address = addr;
        sb_read_strobe = 1'b1;
        @(negedge clock);
        sb_read_strobe = 1'b0;
        latency = 1;
        while (!sb_read_valid && latency < 16) begin
            @(negedge clock);
            latency++;
        end
        if (!sb_read_valid) begin
            report_failure("no sb_read_valid pulse within 16 cycles of the read strobe");
        end else begin
            if (sb_read_data !== expected) begin
                report_mismatch($sformatf("read data at %h", addr), sb_read_data, expected);
            end
            if (latency != 3) begin
                report_mismatch("cycles from read strobe to sb_read_valid", latency, 3);
            end
            @(negedge clock);
            if (sb_read_valid) begin
                report_failure("sb_read_valid stayed high for a second cycle");
            end
            if (sb_read_data !== '0) begin
                report_mismatch("sb_read_data after the pulse", sb_read_data, 0);
            end
            stretch = 1;
            while (!sb_ready && stretch < 32) begin
                @(negedge clock);
                stretch++;
            end
            if (stretch != pulse_stretch_length) begin
                report_mismatch("recovery cycles after read", stretch, pulse_stretch_length);
            end
        end
    endtask

    task automatic run_samples(input int count);
        logic [datapath_width-1:0] sample;
        for (int i = 0; i < count; i++) begin
            sample = datapath_width'($urandom);
            sample_valid = 1'b1;
            sample_data = sample;
            mirror_sample(sample);
            @(negedge clock);
            sample_valid = 1'b0;
            @(negedge clock);
        end
        // Last sample lands two cycles after its pulse
        repeat (2) @(negedge clock);
    endtask

    initial begin
        int fd;
        int code;
        string op;
        string expect_text;
        string rest;
        logic [bus_width-1:0] addr;
        logic [bus_width-1:0] data;
        logic [bus_width-1:0] expected;

        void'($urandom(32'h2a4b));
        reset = 1'b0;
        sb_address = '0;
        sb_write_data = '0;
        sb_write_strobe = 1'b0;
        sb_read_strobe = 1'b0;
        sample_valid = 1'b0;
        sample_data = '0;
        foreach (mirror_regs[i]) mirror_regs[i] = '0;
        mirror_channels = '0;
        mirror_index = 0;

        fd = $fopen("tests/dma_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open tests/dma_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %s", addr, data, expect_text);
                    vec_op.push_back(op);
                    vec_addr.push_back(addr);
                    vec_data.push_back(data);
                    vec_expect.push_back(expect_text);
                end
            end
            $fclose(fd);
        end
        if (vec_op.size() == 0) begin
            report_failure("the vector file holds no operations");
        end
        vector_count = vec_op.size();

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        if (sb_ready !== 1'b1) report_mismatch("sb_ready after reset", sb_ready, 1);
        if (sb_read_valid !== 1'b0) report_mismatch("sb_read_valid after reset", sb_read_valid, 0);
        report_result("reset state");

        for (int i = 0; i < vector_count; i++) begin
            test_errors = 0;
            if (vec_op[i] == "write") begin
                host_write(vec_addr[i], vec_data[i], 1'b0);
            end else if (vec_op[i] == "set_channels") begin
                host_write(base_address, vec_data[i], 1'b0);
            end else if (vec_op[i] == "collide") begin
                host_write(vec_addr[i], vec_data[i], 1'b1);
            end else if (vec_op[i] == "sample") begin
                run_samples(int'(vec_data[i]));
            end else if (vec_op[i] == "read") begin
                if (vec_expect[i] == "m") begin
                    expected = mirror_read(vec_addr[i]);
                end else begin
                    code = $sscanf(vec_expect[i], "%h", expected);
                end
                host_read(vec_addr[i], expected);
            end else begin
                report_failure($sformatf("unknown operation %s", vec_op[i]));
            end
            report_result($sformatf("vector %0d %s %h", i, vec_op[i], vec_addr[i]));
        end

        $display("Totals: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tests/dma_vectors.txt ====
# op  address  data  expected (hex, m = from the register mirror, - = none)
# sample takes its count in the data column, set_channels its channel count
read         43c00000 00000000 00000000
read         43c00004 00000000 00000000
read         43c00100 00000000 00000000
write        43c00004 fff12345 -
read         43c00004 00000000 00012345
write        43c00018 000abcde -
read         43c00018 00000000 000abcde
write        43c00100 8007ffff -
read         43c00100 00000000 0007ffff
read         43c00004 00000000 00012345
write        43c00000 abcd0103 -
read         43c00000 00000000 00000003
set_channels 43c00000 00000004 -
sample       00000000 0000000a -
read         43c00004 00000000 m
read         43c00008 00000000 m
read         43c0000c 00000000 m
read         43c00010 00000000 m
read         43c00014 00000000 00000000
read         43c00018 00000000 000abcde
set_channels 43c00000 00000000 -
sample       00000000 00000008 -
read         43c00004 00000000 m
read         43c00010 00000000 m
set_channels 43c00000 00000002 -
collide      43c0002c 00055555 -
read         43c00004 00000000 m
read         43c0002c 00000000 00055555
collide      43c00054 000f0f0f -
read         43c00008 00000000 m
read         43c00054 00000000 000f0f0f
set_channels 43c00000 00000050 -
sample       00000000 00000046 -
read         43c00004 00000000 m
read         43c00018 00000000 m
read         43c0001c 00000000 m
read         43c00100 00000000 m
read         43c00000 00000000 00000050

// ==== src.f ====
verilog/fcore_pkg.sv
verilog/register_file.sv
verilog/sample_streamer.sv
verilog/dma_endpoint.sv
verilog/fcore_dma_top.sv
tests/tb_fcore_dma.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_fcore_dma
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check for a pass"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
